// ==== Bender.yml ====
package:
  name: vec_ctrl

sources:
  - files:
      - verilog/vec_pkg.sv
      - verilog/vec_decoder.sv
      - verilog/vec_req_fifo.sv
      - verilog/vec_csr_unit.sv
      - verilog/vec_ctrl_top.sv
  - target: test
    files:
      - testbench/tb_vec_ctrl.sv

// ==== sim.f ====
verilog/vec_pkg.sv
verilog/vec_decoder.sv
verilog/vec_req_fifo.sv
verilog/vec_csr_unit.sv
verilog/vec_ctrl_top.sv
testbench/tb_vec_ctrl.sv

// ==== testbench/tb_vec_ctrl.sv ====
/*
 * Testbench for the vector configuration front end
 * Drives vset* and vector CSR instructions, mirrors the CSR state
 * and checks every writeback result in order
 */

`default_nettype none

module tb_vec_ctrl;

	timeunit 1ns;
	timeprecision 1ps;

	import vec_pkg::*;

	localparam int unsigned VLEN          = 256;
	localparam int unsigned FIFO_DEPTH    = 4;
	localparam int          SEND_TIMEOUT  = 200; // Cycles
	localparam int          DRAIN_TIMEOUT = 500;

	logic      clk_i;
	logic      reset_i;
	instr_t    instr_i;
	logic      instr_valid_i;
	xlen_t     rs1_i;
	xlen_t     rs2_i;
	logic      stall_i;
	logic      instr_illegal_o;
	logic      full_o;
	logic      result_valid_o;
	reg_addr_t result_rd_o;
	xlen_t     result_data_o;

	// Mirrored CSR state
	xlen_t      m_vl;
	vtype_t     m_vtype;
	xlen_t      m_vstart;
	logic       m_vxsat;
	logic [1:0] m_vxrm;

	reg_addr_t exp_rd [$];
	xlen_t     exp_data [$];
	logic      saw_full;
	logic      stall_en;

	vec_ctrl_top #(
		.VLEN       (VLEN),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_dut (
		.clk_i           (clk_i),
		.reset_i         (reset_i),
		.instr_i         (instr_i),
		.instr_valid_i   (instr_valid_i),
		.rs1_i           (rs1_i),
		.rs2_i           (rs2_i),
		.stall_i         (stall_i),
		.instr_illegal_o (instr_illegal_o),
		.full_o          (full_o),
		.result_valid_o  (result_valid_o),
		.result_rd_o     (result_rd_o),
		.result_data_o   (result_data_o)
	);

	always #5 clk_i = ~clk_i;

	// Writeback port busy at random
	always @(posedge clk_i) begin
		if (stall_en)
			stall_i <= ($urandom_range(0, 9) < 4);
		else
			stall_i <= 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Failure reporting
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input xlen_t got, input xlen_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Instruction encoding
	//////////////////////////////////////////////////////////////////////

	function automatic instr_t vsetvli_word(input reg_addr_t rd, input reg_addr_t rs1,
			input logic [10:0] zimm);
		return {1'b0, zimm, rs1, OPCFG, rd, OPCODE_VEC};
	endfunction

	function automatic instr_t vsetivli_word(input reg_addr_t rd, input logic [4:0] uimm,
			input logic [9:0] zimm);
		return {2'b11, zimm, uimm, OPCFG, rd, OPCODE_VEC};
	endfunction

	function automatic instr_t vsetvl_word(input reg_addr_t rd, input reg_addr_t rs1);
		return {7'b1000000, 5'd2, rs1, OPCFG, rd, OPCODE_VEC}; // rs2 value comes on rs2_i
	endfunction

	function automatic instr_t csr_word(input logic [2:0] f3, input reg_addr_t rd,
			input reg_addr_t rs1, input csr_addr_t addr);
		return {addr, rs1, f3, rd, OPCODE_SYSTEM};
	endfunction

	function automatic csr_addr_t csr_by_index(input int idx);
		case (idx)
			0: return CSR_VSTART;
			1: return CSR_VXSAT;
			2: return CSR_VXRM;
			3: return CSR_VCSR;
			4: return CSR_VL;
			5: return CSR_VTYPE;
			6: return CSR_VLENB;
			default: return 12'h123; // Not a vector CSR
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model, returns the expected illegal flag
	//////////////////////////////////////////////////////////////////////

	function automatic logic ref_model(input instr_t instr, input xlen_t rs1v, input xlen_t rs2v);
		logic [2:0] f3;
		reg_addr_t  rd;
		reg_addr_t  rs1;
		csr_addr_t  addr;
		vtype_t     vt;
		xlen_t      avl;
		xlen_t      vlmax;
		xlen_t      old;
		xlen_t      operand;
		xlen_t      wr;
		logic       pure_rd;
		int         sew;
		int         lmul;

		f3   = instr[14:12];
		rd   = instr[11:7];
		rs1  = instr[19:15];
		addr = instr[31:20];
		avl  = rs1v;

		if (instr[6:0] == OPCODE_VEC && f3 == OPCFG) begin
			if (instr[31] == 1'b0) begin
				vt = {instr[30:28] != 3'b0, instr[27:20]};
			end else if (instr[31:30] == 2'b11) begin
				vt  = {instr[29:28] != 2'b0, instr[27:20]};
				avl = xlen_t'(rs1); // Immediate AVL
			end else if (instr[31:25] == 7'b1000000) begin
				vt = {rs2v[31:8] != 24'b0, rs2v[7:0]};
			end else begin
				return 1'b1;
			end
			sew  = vt[5:3];
			lmul = vt[2:0];
			if (vt[8] || sew > 3 || lmul > 3) begin
				m_vl    = '0;
				m_vtype = VTYPE_ILL;
			end else begin
				vlmax   = (VLEN / (8 << sew)) * (1 << lmul);
				m_vtype = vt;
				if (instr[31:30] != 2'b11 && rs1 == '0) begin
					if (rd != '0)
						m_vl = vlmax;
				end else begin
					m_vl = (avl < vlmax) ? avl : vlmax;
				end
			end
			m_vstart = '0;
			exp_rd.push_back(rd);
			exp_data.push_back(m_vl);
			return 1'b0;
		end

		if (instr[6:0] != OPCODE_SYSTEM || f3[1:0] == 2'b00)
			return 1'b1;

		operand = f3[2] ? xlen_t'(rs1) : rs1v;
		pure_rd = (f3[1:0] != 2'b01) && (rs1 == '0);
		case (addr)
			CSR_VSTART: old = m_vstart;
			CSR_VXSAT:  old = xlen_t'(m_vxsat);
			CSR_VXRM:   old = xlen_t'(m_vxrm);
			CSR_VCSR:   old = xlen_t'({m_vxrm, m_vxsat});
			CSR_VL:     old = m_vl;
			CSR_VTYPE:  old = {m_vtype[8], 23'b0, m_vtype[7:0]};
			CSR_VLENB:  old = VLEN / 8;
			default:    return 1'b1;
		endcase

		if (!pure_rd) begin
			if (addr == CSR_VL || addr == CSR_VTYPE || addr == CSR_VLENB)
				return 1'b1; // Read-only
			case (f3[1:0])
				2'b01:   wr = operand;
				2'b10:   wr = old | operand;
				default: wr = old & ~operand;
			endcase
			case (addr)
				CSR_VSTART: m_vstart = wr % VLEN;
				CSR_VXSAT:  m_vxsat  = wr[0];
				CSR_VXRM:   m_vxrm   = wr[1:0];
				default:    {m_vxrm, m_vxsat} = wr[2:0];
			endcase
		end

		if (f3[1:0] != 2'b01 || rd != '0) begin
			exp_rd.push_back(rd);
			exp_data.push_back(old);
		end
		return 1'b0;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// Called on a rising edge, returns on the edge that takes the instruction
	task automatic send_instr(input instr_t instr, input xlen_t rs1v, input xlen_t rs2v);
		int   waited;
		logic done;
		logic ill;

		waited = 0;
		done   = 1'b0;
		while (!done) begin
			if (full_o) begin
				instr_valid_i <= 1'b0;
			end else begin
				instr_i       <= instr;
				rs1_i         <= rs1v;
				rs2_i         <= rs2v;
				instr_valid_i <= 1'b1;
			end
			@(posedge clk_i);
			if (instr_valid_i && !full_o) begin
				ill = ref_model(instr, rs1v, rs2v);
				check_value("instr_illegal_o", instr_illegal_o, ill);
				done = 1'b1;
			end else if (instr_valid_i) begin
				check_value("instr_illegal_o on dropped instruction", instr_illegal_o, 0);
			end
			waited++;
			if (waited > SEND_TIMEOUT)
				abort_run("Timeout: the queue never accepted an instruction");
		end
	endtask

	task automatic random_instr();
		reg_addr_t rd;
		rd = reg_addr_t'($urandom_range(0, 31));
		case ($urandom_range(0, 5))
			0: send_instr(vsetvli_word(rd, 5'($urandom_range(0, 3)), 11'($urandom_range(0, 255))),
					$urandom_range(0, 300), 0);
			1: send_instr(vsetivli_word(rd, 5'($urandom_range(0, 31)), 10'($urandom_range(0, 255))),
					0, 0);
			2: send_instr(vsetvl_word(rd, 5'($urandom_range(0, 3))), $urandom_range(0, 300),
					$urandom_range(0, 255));
			3, 4: send_instr(csr_word(3'($urandom_range(0, 7)), rd, 5'($urandom_range(0, 3)),
					csr_by_index($urandom_range(0, 7))), $urandom, 0);
			default: send_instr(($urandom & 32'hFFFF_FF80) | 32'h33, 0, 0); // Integer OP
		endcase
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_rd.size() != 0) begin
			@(posedge clk_i);
			waited++;
			if (waited > DRAIN_TIMEOUT)
				abort_run("Timeout: expected results never came out of the DUT");
		end
		for (int i = 0; i < 8; i++)
			@(posedge clk_i); // Window for stray results
	endtask

	//////////////////////////////////////////////////////////////////////
	// Result comparison
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk_i) begin : compare
		logic      holding;
		reg_addr_t held_rd;
		xlen_t     held_data;

		if (!reset_i) begin
			if (full_o)
				saw_full <= 1'b1;
			if (!instr_valid_i)
				check_value("instr_illegal_o without valid", instr_illegal_o, 0);
			if (result_valid_o === 1'b1) begin
				if (holding) begin
					check_value("result_rd_o held in stall", result_rd_o, held_rd);
					check_value("result_data_o held in stall", result_data_o, held_data);
				end
				if (stall_i) begin
					holding   = 1'b1;
					held_rd   = result_rd_o;
					held_data = result_data_o;
				end else begin
					if (exp_rd.size() == 0)
						abort_run("A result came out with no instruction waiting for it");
					check_value("result_rd_o", result_rd_o, exp_rd.pop_front());
					check_value("result_data_o", result_data_o, exp_data.pop_front());
					holding = 1'b0;
				end
			end else begin
				if (holding === 1'b1)
					abort_run("result_valid_o dropped while the writeback port stalled");
				holding = 1'b0;
			end
		end else begin
			holding = 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		int unsigned seed;
		logic [7:0]  vt8;
		logic [2:0]  f3;

		seed = 62083;
		void'($urandom(seed));
		clk_i          = 1'b0;
		reset_i        = 1'b1;
		instr_i        = '0;
		instr_valid_i  = 1'b0;
		rs1_i          = '0;
		rs2_i          = '0;
		stall_i        = 1'b0;
		stall_en       = 1'b0;
		saw_full       = 1'b0;
		m_vl           = '0;
		m_vtype        = VTYPE_ILL;
		m_vstart       = '0;
		m_vxsat        = 1'b0;
		m_vxrm         = '0;

		repeat (5) @(posedge clk_i);
		reset_i <= 1'b0;
		check_value("result_valid_o after reset", result_valid_o, 0);
		check_value("full_o after reset", full_o, 0);

		// Every legal SEW/LMUL pair, all three encodings
		for (int sew = 0; sew < 4; sew++) begin
			for (int lmul = 0; lmul < 4; lmul++) begin
				vt8 = {2'($urandom_range(0, 3)), 3'(sew), 3'(lmul)};
				send_instr(vsetvli_word(5'd10, 5'd11, {3'b0, vt8}), $urandom_range(0, 300), 0);
				send_instr(vsetivli_word(5'd12, 5'($urandom_range(0, 31)), {2'b0, vt8}), 0, 0);
				send_instr(vsetvl_word(5'd13, 5'd14), $urandom_range(0, 300), {24'b0, vt8});
				send_instr(vsetvli_word(5'd15, 5'd0, {3'b0, vt8}), $urandom, 0); // VLMAX
				send_instr(vsetvl_word(5'd0, 5'd0), 0, {24'b0, vt8});            // Keep vl
				send_instr(csr_word(3'b010, 5'd1, 5'd0, CSR_VL), 0, 0);
			end
		end

		// Reserved SEW, fractional LMUL, reserved vtype bits
		for (int k = 4; k < 8; k++) begin
			send_instr(vsetvli_word(5'd10, 5'd11, {5'b0, 3'(k), 3'b000}), 20, 0);
			send_instr(csr_word(3'b010, 5'd2, 5'd0, CSR_VTYPE), 0, 0);
			send_instr(vsetvli_word(5'd10, 5'd11, {5'b0, 3'b000, 3'(k)}), 20, 0);
			send_instr(csr_word(3'b010, 5'd2, 5'd0, CSR_VTYPE), 0, 0);
		end
		send_instr(vsetvli_word(5'd10, 5'd11, 11'h400), 20, 0);
		send_instr(vsetvl_word(5'd10, 5'd11), 20, 32'h8000_0000);
		send_instr(csr_word(3'b010, 5'd2, 5'd0, CSR_VTYPE), 0, 0);

		// Writable CSRs in every access form, each followed by a read
		for (int a = 0; a < 4; a++) begin
			for (int k = 0; k < 6; k++) begin
				f3 = (k < 3) ? 3'(k + 1) : 3'(k + 2);
				send_instr(csr_word(f3, 5'($urandom_range(1, 31)), 5'($urandom_range(0, 31)),
						csr_by_index(a)), $urandom, 0);
				send_instr(csr_word(3'b010, 5'd3, 5'd0, csr_by_index(a)), 0, 0);
			end
		end
		send_instr(csr_word(3'b001, 5'd0, 5'd7, CSR_VXRM), 32'h2, 0); // No writeback
		send_instr(csr_word(3'b110, 5'd3, 5'd0, CSR_VCSR), 0, 0);
		send_instr(csr_word(3'b010, 5'd3, 5'd0, CSR_VLENB), 0, 0);

		// Illegal forms, then read everything back
		send_instr(csr_word(3'b001, 5'd1, 5'd5, CSR_VL), 7, 0);
		send_instr(csr_word(3'b101, 5'd1, 5'd3, CSR_VTYPE), 0, 0);
		send_instr(csr_word(3'b010, 5'd1, 5'd5, CSR_VLENB), 1, 0);
		send_instr(csr_word(3'b111, 5'd1, 5'd3, CSR_VL), 0, 0);
		send_instr(csr_word(3'b010, 5'd1, 5'd0, 12'h300), 0, 0);
		send_instr(csr_word(3'b010, 5'd1, 5'd0, 12'h00B), 0, 0);
		send_instr(32'h0020_81B3, 0, 0);                        // add
		send_instr(32'h0220_8057, 0, 0);                        // vadd.vv
		send_instr(32'h0000_0073, 0, 0);                        // ecall
		send_instr(32'h8200_7057 | (32'd1 << 25), 1, 2);        // vsetvl with bad funct7
		for (int a = 0; a < 7; a++)
			send_instr(csr_word(3'b010, 5'd4, 5'd0, csr_by_index(a)), 0, 0);

		// vstart is cleared by vset*
		send_instr(csr_word(3'b001, 5'd4, 5'd5, CSR_VSTART), 17, 0);
		send_instr(vsetvli_word(5'd6, 5'd7, 11'h008), 9, 0);
		send_instr(csr_word(3'b010, 5'd6, 5'd0, CSR_VSTART), 0, 0);

		// Back-to-back traffic against a stalling writeback port
		stall_en <= 1'b1;
		for (int n = 0; n < 120; n++)
			random_instr();
		stall_en      <= 1'b0;
		instr_valid_i <= 1'b0;
		wait_drain();

		if (!saw_full) begin
			abort_run("full_o never rose while the queue was flooded");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule : tb_vec_ctrl

`default_nettype wire

// ==== verilog/vec_csr_unit.sv ====
/*
 * Vector CSR unit
 * Holds vl, vtype, vstart, vxsat and vxrm, executes queued requests
 * and returns the rd writeback value
 */

`default_nettype none

module vec_csr_unit #(
	parameter int unsigned VLEN = 256
) (
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic               not_empty_i,
	input  logic               stall_i, // Writeback port busy
	// Head of the request queue
	input  vec_pkg::vec_op_e   op_i,
	input  vec_pkg::reg_addr_t rd_i,
	input  logic               use_rd_i,
	input  vec_pkg::xlen_t     rs1_i,
	input  vec_pkg::vtype_t    vtype_i,
	input  vec_pkg::csr_addr_t csr_addr_i,
	input  logic               keep_vl_i,
	input  logic               maxvl_i,
	output logic               pop_o,
	// Writeback
	output logic               result_valid_o,
	output vec_pkg::reg_addr_t result_rd_o,
	output vec_pkg::xlen_t     result_data_o
);

	import vec_pkg::*;

	localparam int unsigned VSTART_W = $clog2(VLEN);
	localparam xlen_t       VLENB    = xlen_t'(VLEN / 8);

	// Architectural state
	xlen_t               vl_q;
	vtype_t              vtype_q;
	logic [VSTART_W-1:0] vstart_q;
	logic                vxsat_q;
	logic [1:0]          vxrm_q;

	vsew_t  sew;
	vlmul_t lmul;
	logic   cfg_ill;
	xlen_t  vlmax;
	xlen_t  cfg_vl;
	vtype_t cfg_vtype;
	xlen_t  csr_old;
	xlen_t  csr_new;
	xlen_t  result;

	assign pop_o = not_empty_i & ~stall_i;

	//////////////////////////////////////////////////////////////////////
	// vset* path
	//////////////////////////////////////////////////////////////////////

	assign sew  = vtype_i[5:3];
	assign lmul = vtype_i[2:0];

	// SEW above 64 and fractional LMUL are unsupported
	assign cfg_ill = vtype_i[8] | sew[2] | lmul[2];

	assign vlmax = (xlen_t'(VLEN) >> (3 + sew[1:0])) << lmul[1:0];

	always_comb begin
		if (cfg_ill)
			cfg_vl = '0;
		else if (maxvl_i)
			cfg_vl = vlmax;
		else if (keep_vl_i)
			cfg_vl = vl_q;
		else
			cfg_vl = (rs1_i < vlmax) ? rs1_i : vlmax; // min(AVL, VLMAX)
	end

	assign cfg_vtype = cfg_ill ? VTYPE_ILL : vtype_i;

	//////////////////////////////////////////////////////////////////////
	// CSR path
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (csr_addr_i)
			CSR_VSTART: csr_old = xlen_t'(vstart_q);
			CSR_VXSAT:  csr_old = xlen_t'(vxsat_q);
			CSR_VXRM:   csr_old = xlen_t'(vxrm_q);
			CSR_VCSR:   csr_old = xlen_t'({vxrm_q, vxsat_q});
			CSR_VL:     csr_old = vl_q;
			CSR_VTYPE:  csr_old = {vtype_q[8], 23'b0, vtype_q[7:0]}; // vill sits at the MSB
			CSR_VLENB:  csr_old = VLENB;
			default:    csr_old = '0;
		endcase
	end

	always_comb begin
		case (op_i)
			OP_CSRW: csr_new = rs1_i;
			OP_CSRS: csr_new = csr_old | rs1_i;
			OP_CSRC: csr_new = csr_old & ~rs1_i;
			default: csr_new = csr_old;
		endcase
	end

	assign result = (op_i == OP_VCFG) ? cfg_vl : csr_old;

	//////////////////////////////////////////////////////////////////////
	// State update
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			vl_q           <= '0;
			vtype_q        <= VTYPE_ILL;
			vstart_q       <= '0;
			vxsat_q        <= 1'b0;
			vxrm_q         <= '0;
			result_valid_o <= 1'b0;
		end else if (!stall_i) begin
			result_valid_o <= pop_o & use_rd_i;
			if (pop_o) begin
				if (op_i == OP_VCFG) begin
					vl_q     <= cfg_vl;
					vtype_q  <= cfg_vtype;
					vstart_q <= '0;
				end else begin
					case (csr_addr_i)
						CSR_VSTART: vstart_q <= csr_new[VSTART_W-1:0];
						CSR_VXSAT:  vxsat_q  <= csr_new[0];
						CSR_VXRM:   vxrm_q   <= csr_new[1:0];
						CSR_VCSR: begin
							vxrm_q  <= csr_new[2:1];
							vxsat_q <= csr_new[0];
						end
						default: ; // Read-only registers
					endcase
				end
			end
		end
	end

	// Result payload, held while stalled
	always_ff @(posedge clk_i) begin
		if (pop_o) begin
			result_rd_o   <= rd_i;
			result_data_o <= result;
		end
	end

endmodule : vec_csr_unit

`default_nettype wire

// ==== verilog/vec_ctrl_top.sv ====
/*
 * Vector configuration front end
 * Decoder feeding a request queue that drains into the CSR unit
 */

`default_nettype none

module vec_ctrl_top #(
	parameter int unsigned VLEN       = 256,
	parameter int unsigned FIFO_DEPTH = 4
) (
	input  logic               clk_i,
	input  logic               reset_i,
	input  vec_pkg::instr_t    instr_i,
	input  logic               instr_valid_i,
	input  vec_pkg::xlen_t     rs1_i,
	input  vec_pkg::xlen_t     rs2_i,
	input  logic               stall_i,
	output logic               instr_illegal_o,
	output logic               full_o,
	output logic               result_valid_o,
	output vec_pkg::reg_addr_t result_rd_o,
	output vec_pkg::xlen_t     result_data_o
);

	import vec_pkg::*;

	// Decoder to queue
	logic      push;
	vec_op_e   req_op;
	reg_addr_t req_rd;
	logic      req_use_rd;
	xlen_t     req_rs1;
	vtype_t    req_vtype;
	csr_addr_t req_csr_addr;
	logic      req_keep_vl;
	logic      req_maxvl;

	// Queue head to CSR unit
	logic      pop;
	logic      not_empty;
	vec_op_e   head_op;
	reg_addr_t head_rd;
	logic      head_use_rd;
	xlen_t     head_rs1;
	vtype_t    head_vtype;
	csr_addr_t head_csr_addr;
	logic      head_keep_vl;
	logic      head_maxvl;

	vec_decoder i_decoder (
		.instr_i         (instr_i),
		.instr_valid_i   (instr_valid_i),
		.rs1_i           (rs1_i),
		.rs2_i           (rs2_i),
		.full_i          (full_o),
		.instr_illegal_o (instr_illegal_o),
		.push_o          (push),
		.op_o            (req_op),
		.rd_o            (req_rd),
		.use_rd_o        (req_use_rd),
		.rs1_o           (req_rs1),
		.vtype_o         (req_vtype),
		.csr_addr_o      (req_csr_addr),
		.keep_vl_o       (req_keep_vl),
		.maxvl_o         (req_maxvl)
	);

	vec_req_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_req_fifo (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.push_i      (push),
		.pop_i       (pop),
		.op_i        (req_op),
		.rd_i        (req_rd),
		.use_rd_i    (req_use_rd),
		.rs1_i       (req_rs1),
		.vtype_i     (req_vtype),
		.csr_addr_i  (req_csr_addr),
		.keep_vl_i   (req_keep_vl),
		.maxvl_i     (req_maxvl),
		.full_o      (full_o),
		.not_empty_o (not_empty),
		.op_o        (head_op),
		.rd_o        (head_rd),
		.use_rd_o    (head_use_rd),
		.rs1_o       (head_rs1),
		.vtype_o     (head_vtype),
		.csr_addr_o  (head_csr_addr),
		.keep_vl_o   (head_keep_vl),
		.maxvl_o     (head_maxvl)
	);

	vec_csr_unit #(
		.VLEN (VLEN)
	) i_csr_unit (
		.clk_i          (clk_i),
		.reset_i        (reset_i),
		.not_empty_i    (not_empty),
		.stall_i        (stall_i),
		.op_i           (head_op),
		.rd_i           (head_rd),
		.use_rd_i       (head_use_rd),
		.rs1_i          (head_rs1),
		.vtype_i        (head_vtype),
		.csr_addr_i     (head_csr_addr),
		.keep_vl_i      (head_keep_vl),
		.maxvl_i        (head_maxvl),
		.pop_o          (pop),
		.result_valid_o (result_valid_o),
		.result_rd_o    (result_rd_o),
		.result_data_o  (result_data_o)
	);

endmodule : vec_ctrl_top

`default_nettype wire

// ==== verilog/vec_decoder.sv ====
/*
 * Vector instruction decoder
 * Turns vset* and vector Zicsr instructions into request queue entries,
 * flags everything else as illegal
 */

`default_nettype none

module vec_decoder (
	// Instruction from the scalar core
	input  vec_pkg::instr_t    instr_i,
	input  logic               instr_valid_i,
	input  vec_pkg::xlen_t     rs1_i,
	input  vec_pkg::xlen_t     rs2_i,
	// Queue status
	input  logic               full_i,
	output logic               instr_illegal_o,
	// Queue write side
	output logic               push_o,
	output vec_pkg::vec_op_e   op_o,
	output vec_pkg::reg_addr_t rd_o,
	output logic               use_rd_o,
	output vec_pkg::xlen_t     rs1_o,
	output vec_pkg::vtype_t    vtype_o,
	output vec_pkg::csr_addr_t csr_addr_o,
	output logic               keep_vl_o,
	output logic               maxvl_o
);

	import vec_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Instruction fields
	//////////////////////////////////////////////////////////////////////

	reg_addr_t  rd_field;
	reg_addr_t  rs1_field; // Also the 5-bit immediate
	logic [2:0] funct3;
	csr_addr_t  csr_field;
	logic       accept;    // Instruction seen while the queue has room
	logic       pure_read; // Set or clear with a zero operand
	logic       illegal;

	assign rd_field  = instr_i[11:7];
	assign rs1_field = instr_i[19:15];
	assign funct3    = instr_i[14:12];
	assign csr_field = instr_i[31:20];

	assign accept    = instr_valid_i & ~full_i;
	assign pure_read = funct3[1] & (rs1_field == '0);

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin : decode
		illegal    = 1'b0;
		op_o       = OP_VCFG;
		rd_o       = rd_field;
		use_rd_o   = 1'b1;
		rs1_o      = rs1_i;
		vtype_o    = '0;
		csr_addr_o = '0;
		keep_vl_o  = 1'b0;
		maxvl_o    = 1'b0;

		case (instr_i[6:0])
			OPCODE_VEC: begin
				if (funct3 != OPCFG) begin
					illegal = 1'b1; // Vector arithmetic not handled here
				end else if (!instr_i[31]) begin
					// vsetvli, reserved zimm bits force vill
					vtype_o   = {|instr_i[30:28], instr_i[27:20]};
					maxvl_o   = (rs1_field == '0) && (rd_field != '0);
					keep_vl_o = (rs1_field == '0) && (rd_field == '0);
				end else if (instr_i[30]) begin
					// vsetivli
					vtype_o = {|instr_i[29:28], instr_i[27:20]};
					rs1_o   = xlen_t'(rs1_field); // AVL from uimm
				end else if (instr_i[29:25] == '0) begin
					// vsetvl, vtype taken from rs2
					vtype_o   = {|rs2_i[31:8], rs2_i[7:0]};
					maxvl_o   = (rs1_field == '0) && (rd_field != '0);
					keep_vl_o = (rs1_field == '0) && (rd_field == '0);
				end else begin
					illegal = 1'b1;
				end
			end

			OPCODE_SYSTEM: begin
				csr_addr_o = csr_field;
				if (instr_i[14])
					rs1_o = xlen_t'(rs1_field); // Immediate forms

				case (funct3[1:0])
					2'b01: begin
						op_o     = OP_CSRW;
						use_rd_o = rd_field != '0; // No read side effect wanted
					end
					2'b10: op_o = OP_CSRS;
					2'b11: op_o = OP_CSRC;
					default: illegal = 1'b1; // ECALL, EBREAK, xRET and friends
				endcase

				if (pure_read) begin
					op_o  = OP_CSRS;
					rs1_o = '0;
				end

				// Only reads reach the read-only registers
				case (csr_field)
					CSR_VSTART, CSR_VXSAT, CSR_VXRM, CSR_VCSR: ;
					CSR_VL, CSR_VTYPE, CSR_VLENB: begin
						if (!pure_read)
							illegal = 1'b1;
					end
					default: illegal = 1'b1;
				endcase
			end

			default: illegal = 1'b1;
		endcase
	end

	// A full queue drops the instruction silently
	assign instr_illegal_o = accept & illegal;
	assign push_o          = accept & ~illegal;

endmodule : vec_decoder

`default_nettype wire

// ==== verilog/vec_pkg.sv ====
/*
 * Vector configuration front end shared definitions
 * Instruction field constants, CSR addresses, vtype layout and request ops
 */

`default_nettype none

package vec_pkg;

	//////////////////////////////////////////////////////////////////////
	// Basic widths
	//////////////////////////////////////////////////////////////////////

	typedef logic [31:0] instr_t;    // Raw instruction word
	typedef logic [31:0] xlen_t;     // Scalar register value
	typedef logic [4:0]  reg_addr_t; // x-register index
	typedef logic [11:0] csr_addr_t;

	// vtype layout {vill, vma, vta, vsew[2:0], vlmul[2:0]}
	typedef logic [8:0] vtype_t;
	typedef logic [2:0] vsew_t;
	typedef logic [2:0] vlmul_t;

	// Value loaded into vtype on reset or on an unsupported configuration
	localparam vtype_t VTYPE_ILL = 9'h100;

	//////////////////////////////////////////////////////////////////////
	// Request operations
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		OP_VCFG = 3'd0, // vsetvli, vsetivli, vsetvl
		OP_CSRW = 3'd1, // CSRRW / CSRRWI
		OP_CSRS = 3'd2, // CSRRS / CSRRSI, also pure reads
		OP_CSRC = 3'd3  // CSRRC / CSRRCI
	} vec_op_e;

	//////////////////////////////////////////////////////////////////////
	// Opcodes and function codes
	//////////////////////////////////////////////////////////////////////

	localparam logic [6:0] OPCODE_VEC    = 7'b1010111;
	localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

	// Configuration group inside OPCODE_VEC
	localparam logic [2:0] OPCFG = 3'b111;

	//////////////////////////////////////////////////////////////////////
	// Vector CSR addresses
	//////////////////////////////////////////////////////////////////////

	// Read/write, unprivileged
	localparam csr_addr_t CSR_VSTART = 12'h008;
	localparam csr_addr_t CSR_VXSAT  = 12'h009;
	localparam csr_addr_t CSR_VXRM   = 12'h00A;
	localparam csr_addr_t CSR_VCSR   = 12'h00F;

	// Read-only, unprivileged
	localparam csr_addr_t CSR_VL    = 12'hC20;
	localparam csr_addr_t CSR_VTYPE = 12'hC21;
	localparam csr_addr_t CSR_VLENB = 12'hC22;

endpackage : vec_pkg

`default_nettype wire

// ==== verilog/vec_req_fifo.sv ====
/*
 * Request queue between decoder and CSR unit
 * Circular buffer of decoded requests with an occupancy counter
 */

`default_nettype none

module vec_req_fifo #(
	parameter int unsigned FIFO_DEPTH = 4
) (
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic               push_i,
	input  logic               pop_i,
	// Write side
	input  vec_pkg::vec_op_e   op_i,
	input  vec_pkg::reg_addr_t rd_i,
	input  logic               use_rd_i,
	input  vec_pkg::xlen_t     rs1_i,
	input  vec_pkg::vtype_t    vtype_i,
	input  vec_pkg::csr_addr_t csr_addr_i,
	input  logic               keep_vl_i,
	input  logic               maxvl_i,
	// Status
	output logic               full_o,
	output logic               not_empty_o,
	// Head of queue
	output vec_pkg::vec_op_e   op_o,
	output vec_pkg::reg_addr_t rd_o,
	output logic               use_rd_o,
	output vec_pkg::xlen_t     rs1_o,
	output vec_pkg::vtype_t    vtype_o,
	output vec_pkg::csr_addr_t csr_addr_o,
	output logic               keep_vl_o,
	output logic               maxvl_o
);

	import vec_pkg::*;

	localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

	typedef logic [PTR_W-1:0] ptr_t;

	ptr_t             wr_ptr_q;
	ptr_t             rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic             do_push;
	logic             do_pop;

	// Storage, one array per field
	vec_op_e   op_q       [FIFO_DEPTH];
	reg_addr_t rd_q       [FIFO_DEPTH];
	logic      use_rd_q   [FIFO_DEPTH];
	xlen_t     rs1_q      [FIFO_DEPTH];
	vtype_t    vtype_q    [FIFO_DEPTH];
	csr_addr_t csr_addr_q [FIFO_DEPTH];
	logic      keep_vl_q  [FIFO_DEPTH];
	logic      maxvl_q    [FIFO_DEPTH];

	// Wrap for depths that are not a power of two
	function automatic ptr_t next_ptr(input ptr_t ptr);
		return (ptr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full_o      = count_q == CNT_W'(FIFO_DEPTH);
	assign not_empty_o = count_q != '0;
	assign do_pop      = pop_i & not_empty_o;
	assign do_push     = push_i & (~full_o | do_pop); // Full queue takes push with pop

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= next_ptr(wr_ptr_q);
			if (do_pop)
				rd_ptr_q <= next_ptr(rd_ptr_q);
			count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	always_ff @(posedge clk_i) begin
		if (do_push) begin
			op_q[wr_ptr_q]       <= op_i;
			rd_q[wr_ptr_q]       <= rd_i;
			use_rd_q[wr_ptr_q]   <= use_rd_i;
			rs1_q[wr_ptr_q]      <= rs1_i;
			vtype_q[wr_ptr_q]    <= vtype_i;
			csr_addr_q[wr_ptr_q] <= csr_addr_i;
			keep_vl_q[wr_ptr_q]  <= keep_vl_i;
			maxvl_q[wr_ptr_q]    <= maxvl_i;
		end
	end

	assign op_o       = op_q[rd_ptr_q];
	assign rd_o       = rd_q[rd_ptr_q];
	assign use_rd_o   = use_rd_q[rd_ptr_q];
	assign rs1_o      = rs1_q[rd_ptr_q];
	assign vtype_o    = vtype_q[rd_ptr_q];
	assign csr_addr_o = csr_addr_q[rd_ptr_q];
	assign keep_vl_o  = keep_vl_q[rd_ptr_q];
	assign maxvl_o    = maxvl_q[rd_ptr_q];

endmodule : vec_req_fifo

`default_nettype wire
